// File: bench/dm_cases.txt
// op_addr_wdata_expected_mask in hex; op bits 1:0 DMI op (1 read, 2 write), bit 4 cmdbusy_i,
// bit 5 hart error with code in wdata, bit 6 response ready held low
02_10_80000001_00000000_ffffffff
01_10_00000000_00000001_ffffffff
02_10_80000001_00000000_ffffffff
01_10_00000000_80000001_ffffffff
02_10_80010001_00000000_ffffffff
01_11_00000000_000c0082_fffcc0ff
02_10_40020001_00000000_ffffffff
02_10_80030001_00000000_ffffffff
02_10_80050001_00000000_ffffffff
01_11_00000000_0000c082_fffcc0ff
02_10_40000001_00000000_ffffffff
01_11_00000000_000c0082_fffcc0ff
02_10_10000001_00000000_ffffffff
01_10_00000000_00000001_ffffffff
01_11_00000000_00000082_fffcc0ff
02_10_00000003_00000000_ffffffff
02_10_00000001_00000000_ffffffff
01_11_00000000_000c0082_fffcc0ff
02_17_00123456_00000000_ffffffff
12_17_aabbccdd_00000000_ffffffff
01_16_00000000_00000102_ffffffff
11_16_00000000_00001102_ffffffff
02_16_00000700_00000000_ffffffff
01_16_00000000_00000002_ffffffff
20_00_00000003_00000000_ffffffff
01_16_00000000_00000302_ffffffff
02_16_00000700_00000000_ffffffff
02_04_cafe0001_00000000_ffffffff
02_05_5eed0002_00000000_ffffffff
01_04_00000000_cafe0001_ffffffff
01_05_00000000_5eed0002_ffffffff
12_04_deadbeef_00000000_ffffffff
01_04_00000000_cafe0001_ffffffff
01_16_00000000_00000102_ffffffff
41_05_00000000_5eed0002_ffffffff
41_10_00000000_00000001_ffffffff
01_04_00000000_cafe0001_ffffffff
02_10_00000000_00000000_ffffffff
01_04_00000000_00000000_ffffffff
01_10_00000000_00000000_ffffffff

// File: tb.f
+incdir+design
design/dm_pkg.sv
design/dm_hart_if.sv
design/dm_hart_ctrl.sv
design/dm_csr_file.sv
design/dm_resp_fifo.sv
design/dm_top.sv
bench/dm_chk.sv
bench/tb_dm.sv

// File: bench/tb_dm.sv
`include "dm_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module tb_dm;
    import dm_pkg::*;

    localparam int          NrHarts    = `DM_NR_HARTS;
    localparam int          DataCount  = `DM_DATA_COUNT;
    localparam int          RespDepth  = `DM_RESP_DEPTH;
    localparam int          MaxCases   = 64;
    // dmstatus bits that follow the randomized hart inputs
    localparam logic [31:0] StatusRand = 32'h0003_3f00;

    logic                            clk_i;
    logic                            rst_ni;
    logic                            dmi_req_valid_i;
    logic                            dmi_req_ready_o;
    dtm_op_e                         dmi_req_op_i;
    logic [6:0]                      dmi_req_addr_i;
    logic [31:0]                     dmi_req_data_i;
    logic                            dmi_resp_valid_o;
    logic                            dmi_resp_ready_i;
    logic [31:0]                     dmi_resp_data_o;
    logic                            ndmreset_o;
    logic                            dmactive_o;
    logic [NrHarts-1:0]              halted_i;
    logic [NrHarts-1:0]              unavailable_i;
    logic [NrHarts-1:0]              resumeack_i;
    logic [NrHarts-1:0]              haltreq_o;
    logic [NrHarts-1:0]              resumereq_o;
    logic                            cmd_valid_o;
    logic [31:0]                     cmd_o;
    logic                            cmdbusy_i;
    logic                            cmderror_valid_i;
    cmderr_e                         cmderror_i;
    logic [DataCount-1:0][31:0]      data_o;

    // one case: op, address, write data, expected, mask
    logic [111:0] cases [MaxCases];
    logic [31:0]  sb_exp[$];
    logic [31:0]  sb_mask[$];
    logic [31:0]  rng;
    int           ncases;
    int           limit;
    int           errors;
    int           checked;

    // expected register state
    logic                       m_active;
    logic                       m_ndmreset;
    logic                       m_haltreq;
    logic                       m_resumereq;
    logic                       m_cmd_pulse;
    logic [9:0]                 m_hartsel;
    logic [31:0]                m_cmd;
    logic [DataCount-1:0][31:0] m_data;

    dm_top i_dm_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // status of the selected hart as the spec defines it
    function automatic logic [31:0] hart_status_bits();
        logic [31:0] s;
        logic        unav;
        int          sel;
        s   = '0;
        sel = int'(m_hartsel);
        if (sel < NrHarts) begin
            unav     = unavailable_i[sel];
            s[9:8]   = {2{halted_i[sel] & ~unav}};
            s[11:10] = {2{~halted_i[sel] & ~unav}};
            s[13:12] = {2{unav}};
            s[17:16] = {2{resumeack_i[sel]}};
        end
        return s;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic clear_model();
        m_active    = 1'b0;
        m_ndmreset  = 1'b0;
        m_haltreq   = 1'b0;
        m_resumereq = 1'b0;
        m_cmd_pulse = 1'b0;
        m_hartsel   = '0;
        m_cmd       = '0;
        m_data      = '0;
    endtask

    // --------------------------------------------------
    // per-cycle output checks
    // --------------------------------------------------
    task automatic check_outputs();
        logic [NrHarts-1:0] exp_halt;
        logic [NrHarts-1:0] exp_resume;
        int                 sel;
        int                 i;
        exp_halt   = '0;
        exp_resume = '0;
        sel        = int'(m_hartsel);
        if (sel < NrHarts) begin
            exp_halt[sel]   = m_haltreq;
            exp_resume[sel] = m_resumereq;
        end
        compare_value("haltreq_o", 32'(haltreq_o), 32'(exp_halt));
        compare_value("resumereq_o", 32'(resumereq_o), 32'(exp_resume));
        compare_value("dmactive_o", 32'(dmactive_o), 32'(m_active));
        compare_value("ndmreset_o", 32'(ndmreset_o), 32'(m_ndmreset));
        compare_value("cmd_valid_o", 32'(cmd_valid_o), 32'(m_cmd_pulse));
        compare_value("cmd_o", cmd_o, m_cmd);
        for (i = 0; i < DataCount; i++) begin
            compare_value($sformatf("data_o[%0d]", i), data_o[i], m_data[i]);
        end
        // fifo fill equals the number of outstanding responses
        compare_value("dmi_req_ready_o", 32'(dmi_req_ready_o), 32'(sb_exp.size() < RespDepth));
        compare_value("dmi_resp_valid_o", 32'(dmi_resp_valid_o), 32'(sb_exp.size() > 0));
        m_cmd_pulse = 1'b0;
    endtask

    task automatic take_response();
        logic [31:0] e;
        logic [31:0] m;
        if (dmi_resp_valid_o && dmi_resp_ready_i) begin
            assert (sb_exp.size() > 0) else begin
                errors++;
                $display("response delivered with no request outstanding");
            end
            if (sb_exp.size() > 0) begin
                e = sb_exp.pop_front();
                m = sb_mask.pop_front();
                compare_value("dmi_resp_data_o", dmi_resp_data_o & m, e);
                checked++;
            end
        end
    endtask

    // request is taken at the coming edge
    task automatic accept_request(input logic [111:0] c);
        logic [1:0]  op;
        logic [6:0]  addr;
        logic [31:0] wd;
        logic [31:0] e;
        logic [31:0] m;
        logic        busy;
        op   = c[105:104];
        addr = c[102:96];
        wd   = c[95:64];
        e    = c[63:32];
        m    = c[31:0];
        busy = c[108];
        if (op == 2'd1 && addr == 7'(DMStatus)) begin
            e = (e & ~StatusRand) | hart_status_bits();
            m = m | StatusRand;
        end
        sb_exp.push_back(e & m);
        sb_mask.push_back(m);
        if (op == 2'd2) begin
            if (addr == 7'(DMControl)) begin
                if (m_active && wd[0]) begin
                    m_haltreq   = wd[31];
                    m_resumereq = wd[30];
                    m_hartsel   = wd[25:16];
                    m_ndmreset  = wd[1];
                end else begin
                    clear_model();
                end
                m_active = wd[0];
            end else if (m_active && !busy) begin
                if (addr == 7'(Command)) begin
                    m_cmd       = wd;
                    m_cmd_pulse = 1'b1;
                end else if (addr >= 7'(Data0) && addr < 7'(Data0) + 7'(DataCount)) begin
                    m_data[addr - 7'(Data0)] = wd;
                end
            end
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin : main
        logic [111:0] cur;
        logic         loaded;
        logic         hold;
        logic         prev_hold;
        int           idx;
        rst_ni           = 1'b0;
        dmi_req_valid_i  = 1'b0;
        dmi_req_op_i     = DTM_NOP;
        dmi_req_addr_i   = '0;
        dmi_req_data_i   = '0;
        dmi_resp_ready_i = 1'b0;
        halted_i         = '0;
        unavailable_i    = '0;
        resumeack_i      = '0;
        cmdbusy_i        = 1'b0;
        cmderror_valid_i = 1'b0;
        cmderror_i       = CmdErrNone;
        rng              = 32'hda41_df37;
        errors           = 0;
        checked          = 0;
        ncases           = 0;
        cur              = '0;
        loaded           = 1'b0;
        prev_hold        = 1'b0;
        idx              = 0;
        clear_model();

        $readmemh("bench/dm_cases.txt", cases);
        while (ncases < MaxCases && !$isunknown(cases[ncases]) && cases[ncases] != '0) begin
            ncases++;
        end
        assert (ncases > 0) else begin
            errors++;
            $display("no cases read from the case file");
        end
        limit = 40 * ncases;

        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        while (idx < ncases) begin
            @(negedge clk_i);
            check_outputs();
            if (!loaded) begin
                cur              = cases[idx];
                rng              = xorshift32(rng);
                halted_i         = NrHarts'(rng);
                unavailable_i    = NrHarts'(rng >> 8) & NrHarts'(rng >> 16);
                resumeack_i      = NrHarts'(rng >> 24);
                cmdbusy_i        = cur[108];
                cmderror_valid_i = cur[109];
                cmderror_i       = cmderr_e'(cur[66:64]);
                dmi_req_op_i     = dtm_op_e'(cur[105:104]);
                dmi_req_addr_i   = cur[102:96];
                dmi_req_data_i   = cur[95:64];
                loaded           = 1'b1;
            end
            hold             = cur[110];
            rng              = xorshift32(rng);
            dmi_resp_ready_i = hold ? 1'b0 : rng[0];
            dmi_req_valid_i  = 1'b1;
            // empty the buffer before a held run starts
            if (hold && !prev_hold && sb_exp.size() > 0) begin
                dmi_resp_ready_i = 1'b1;
                dmi_req_valid_i  = 1'b0;
            end
            take_response();
            if (dmi_req_valid_i && dmi_req_ready_o) begin
                accept_request(cur);
                prev_hold = hold;
                loaded    = 1'b0;
                idx++;
            end
        end

        while (sb_exp.size() > 0) begin
            @(negedge clk_i);
            check_outputs();
            dmi_req_valid_i  = 1'b0;
            dmi_resp_ready_i = 1'b1;
            cmdbusy_i        = 1'b0;
            cmderror_valid_i = 1'b0;
            take_response();
        end
        @(negedge clk_i);
        check_outputs();

        $display("summary: %0d cases, %0d responses, %0d check errors, %0d assertion errors",
                 ncases, checked, errors, i_dm_top.i_dm_chk.fail_count);
        if (errors == 0 && i_dm_top.i_dm_chk.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (limit == 0 || cycles < limit) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: run exceeded %0d cycles with %0d errors so far", limit, errors);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/dm_chk.sv
`include "dm_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module dm_chk (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    push_i,
    input  logic                    pop_i,
    input  logic                    cmd_valid_i,
    input  logic [`DM_NR_HARTS-1:0] haltreq_i
);

    localparam int Depth = `DM_RESP_DEPTH;

    // failures seen so far, summed into the final count
    int fail_count;

    // entries held, tracked from the push and pop handshakes alone
    int occupancy;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(push_i) - int'(pop_i);
        end
    end

    // --------------------------------------------------
    // handshake and request properties
    // --------------------------------------------------
    push_not_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni) push_i |-> (occupancy < Depth)
    ) else begin
        fail_count++;
        $error("response pushed into a full buffer");
    end

    // command start is a single pulse
    cmd_single_pulse: assert property (
        @(posedge clk_i) disable iff (!rst_ni) cmd_valid_i |=> !cmd_valid_i
    ) else begin
        fail_count++;
        $error("cmd_valid_o high for two cycles in a row");
    end

    haltreq_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_ni) $onehot0(haltreq_i)
    ) else begin
        fail_count++;
        $error("haltreq_o has more than one bit set");
    end

endmodule

bind dm_top dm_chk i_dm_chk (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .push_i      ( resp_push   ),
    .pop_i       ( resp_pop    ),
    .cmd_valid_i ( cmd_valid_o ),
    .haltreq_i   ( haltreq_o   )
);

`default_nettype wire

// File: design/dm_top.sv
`include "dm_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module dm_top (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    // DMI request
    input  logic                            dmi_req_valid_i,
    output logic                            dmi_req_ready_o,
    input  dm_pkg::dtm_op_e                 dmi_req_op_i,
    input  logic [6:0]                      dmi_req_addr_i,
    input  logic [31:0]                     dmi_req_data_i,
    // DMI response
    output logic                            dmi_resp_valid_o,
    input  logic                            dmi_resp_ready_i,
    output logic [31:0]                     dmi_resp_data_o,
    // module control
    output logic                            ndmreset_o,
    output logic                            dmactive_o,
    // hart status and requests
    input  logic [`DM_NR_HARTS-1:0]         halted_i,
    input  logic [`DM_NR_HARTS-1:0]         unavailable_i,
    input  logic [`DM_NR_HARTS-1:0]         resumeack_i,
    output logic [`DM_NR_HARTS-1:0]         haltreq_o,
    output logic [`DM_NR_HARTS-1:0]         resumereq_o,
    // abstract command
    output logic                            cmd_valid_o,
    output logic [31:0]                     cmd_o,
    input  logic                            cmdbusy_i,
    input  logic                            cmderror_valid_i,
    input  dm_pkg::cmderr_e                 cmderror_i,
    output logic [`DM_DATA_COUNT-1:0][31:0] data_o
);

    logic        req_accept;
    logic        resp_push;
    logic        resp_pop;
    logic        resp_full;
    logic        resp_empty;
    logic [31:0] resp_data;

    dm_hart_if hart_if ();

    // --------------------------------------------------
    // DMI handshakes
    // --------------------------------------------------
    assign dmi_req_ready_o  = ~resp_full;
    assign req_accept       = dmi_req_valid_i & dmi_req_ready_o;
    assign dmi_resp_valid_o = ~resp_empty;
    assign resp_pop         = dmi_resp_valid_o & dmi_resp_ready_i;
    assign ndmreset_o       = hart_if.ndmreset;

    dm_csr_file i_dm_csr_file (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .req_accept_i     ( req_accept       ),
        .req_op_i         ( dmi_req_op_i     ),
        .req_addr_i       ( dmi_req_addr_i   ),
        .req_data_i       ( dmi_req_data_i   ),
        .resp_push_o      ( resp_push        ),
        .resp_data_o      ( resp_data        ),
        .dmactive_o       ( dmactive_o       ),
        .hart_if          ( hart_if.csr      ),
        .cmd_valid_o      ( cmd_valid_o      ),
        .cmd_o            ( cmd_o            ),
        .cmdbusy_i        ( cmdbusy_i        ),
        .cmderror_valid_i ( cmderror_valid_i ),
        .cmderror_i       ( cmderror_i       ),
        .data_o           ( data_o           )
    );

    dm_hart_ctrl i_dm_hart_ctrl (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .hart_if       ( hart_if.ctrl  ),
        .halted_i      ( halted_i      ),
        .unavailable_i ( unavailable_i ),
        .resumeack_i   ( resumeack_i   ),
        .haltreq_o     ( haltreq_o     ),
        .resumereq_o   ( resumereq_o   )
    );

    dm_resp_fifo #(
        .DEPTH ( `DM_RESP_DEPTH )
    ) i_dm_resp_fifo (
        .clk_i   ( clk_i           ),
        .rst_ni  ( rst_ni          ),
        .push_i  ( resp_push       ),
        .data_i  ( resp_data       ),
        .full_o  ( resp_full       ),
        .pop_i   ( resp_pop        ),
        .empty_o ( resp_empty      ),
        .data_o  ( dmi_resp_data_o )
    );

endmodule

`default_nettype wire

// File: design/dm_resp_fifo.sv
`include "dm_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module dm_resp_fifo #(
    parameter int DEPTH = `DM_RESP_DEPTH
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        push_i,
    input  logic [31:0] data_i,
    output logic        full_o,
    input  logic        pop_i,
    output logic        empty_o,
    output logic [31:0] data_o
);

    localparam int PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CntW = $clog2(DEPTH + 1);

    logic [31:0]     mem_q [DEPTH];
    logic [PtrW-1:0] wr_ptr_q;
    logic [PtrW-1:0] rd_ptr_q;
    logic [CntW-1:0] count_q;
    logic            do_push;
    logic            do_pop;

    // wrap at DEPTH, not at a power of two
    function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CntW'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;
    assign data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // simultaneous push and pop keeps the count
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

// File: design/dm_csr_file.sv
`include "dm_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module dm_csr_file (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    // accepted DMI request
    input  logic                            req_accept_i,
    input  dm_pkg::dtm_op_e                 req_op_i,
    input  logic [6:0]                      req_addr_i,
    input  logic [31:0]                     req_data_i,
    // response word
    output logic                            resp_push_o,
    output logic [31:0]                     resp_data_o,
    output logic                            dmactive_o,
    dm_hart_if.csr                          hart_if,
    // abstract command
    output logic                            cmd_valid_o,
    output logic [31:0]                     cmd_o,
    input  logic                            cmdbusy_i,
    input  logic                            cmderror_valid_i,
    input  dm_pkg::cmderr_e                 cmderror_i,
    output logic [`DM_DATA_COUNT-1:0][31:0] data_o
);
    import dm_pkg::*;

    localparam int DataCount = `DM_DATA_COUNT;
    localparam int DataIdxW  = (DataCount > 1) ? $clog2(DataCount) : 1;

    dm_wdata_u                   wdata;
    dmcontrol_t                  dmcontrol_d, dmcontrol_q;
    cmderr_e                     cmderr_d, cmderr_q;
    command_t                    command_d, command_q;
    logic [DataCount-1:0][31:0]  data_d, data_q;
    logic                        cmd_valid_d, cmd_valid_q;
    logic                        ack_d, ack_q;
    logic                        active_d;
    logic                        wr_en;
    logic                        is_data;
    logic                        busy_access;
    logic [DataIdxW-1:0]         data_idx;
    dmstatus_t                   dmstatus;
    abstractcs_t                 abstractcs;

    assign wdata    = req_data_i;
    assign wr_en    = req_accept_i && (req_op_i == DTM_WRITE);
    assign is_data  = (req_addr_i >= 7'(Data0)) && (req_addr_i < 7'(Data0) + 7'(DataCount));
    assign data_idx = DataIdxW'(req_addr_i - 7'(Data0));

    // accesses that collide with a running command
    assign busy_access = is_data || (req_addr_i == 7'(AbstractCS))
                         || (req_addr_i == 7'(Command));

    // --------------------------------------------------
    // read-only views
    // --------------------------------------------------
    always_comb begin
        dmstatus                = '0;
        dmstatus.version        = 4'(`DM_DBG_VERSION);
        dmstatus.authenticated  = 1'b1;
        dmstatus.anyhalted      = hart_if.halted;
        dmstatus.allhalted      = hart_if.halted;
        dmstatus.anyrunning     = hart_if.running;
        dmstatus.allrunning     = hart_if.running;
        dmstatus.anyunavail     = hart_if.unavail;
        dmstatus.allunavail     = hart_if.unavail;
        dmstatus.anynonexistent = hart_if.nonexistent;
        dmstatus.allnonexistent = hart_if.nonexistent;
        dmstatus.anyresumeack   = hart_if.resumeack;
        dmstatus.allresumeack   = hart_if.resumeack;
        dmstatus.anyhavereset   = hart_if.havereset;
        dmstatus.allhavereset   = hart_if.havereset;

        abstractcs           = '0;
        abstractcs.datacount = 4'(DataCount);
        abstractcs.cmderr    = cmderr_q;
        abstractcs.busy      = cmdbusy_i;
    end

    // read data, zero for writes and no-ops
    always_comb begin
        resp_data_o = '0;
        if (req_op_i == DTM_READ) begin
            case (req_addr_i)
                DMControl:  resp_data_o = dmcontrol_q;
                DMStatus:   resp_data_o = dmstatus;
                AbstractCS: resp_data_o = abstractcs;
                default: begin
                    if (is_data) begin
                        resp_data_o = data_q[data_idx];
                    end
                end
            endcase
        end
    end

    // --------------------------------------------------
    // register writes
    // --------------------------------------------------
    always_comb begin
        dmcontrol_d = dmcontrol_q;
        cmderr_d    = cmderr_q;
        command_d   = command_q;
        data_d      = data_q;
        cmd_valid_d = 1'b0;
        ack_d       = 1'b0;
        if (wr_en) begin
            case (req_addr_i)
                DMControl: begin
                    dmcontrol_d           = '0;
                    dmcontrol_d.haltreq   = wdata.dmcontrol.haltreq;
                    dmcontrol_d.resumereq = wdata.dmcontrol.resumereq;
                    dmcontrol_d.hartsello = wdata.dmcontrol.hartsello;
                    dmcontrol_d.ndmreset  = wdata.dmcontrol.ndmreset;
                    dmcontrol_d.dmactive  = wdata.dmcontrol.dmactive;
                    ack_d                 = wdata.dmcontrol.ackhavereset;
                end
                AbstractCS: begin
                    // cmderr is write-1-to-clear
                    if (!cmdbusy_i) begin
                        cmderr_d = cmderr_e'(cmderr_q & ~wdata.abstractcs.cmderr);
                    end
                end
                Command: begin
                    if (!cmdbusy_i) begin
                        command_d   = wdata.command;
                        cmd_valid_d = 1'b1;
                    end
                end
                default: begin
                    if (is_data && !cmdbusy_i) begin
                        data_d[data_idx] = req_data_i;
                    end
                end
            endcase
            if (busy_access && cmdbusy_i && (cmderr_q == CmdErrNone)) begin
                cmderr_d = CmdErrBusy;
            end
        end
        // the hart's report wins over the bus
        if (cmderror_valid_i) begin
            cmderr_d = cmderror_i;
        end
    end

    // module stays cleared unless active before and after the edge
    assign active_d = dmcontrol_q.dmactive & dmcontrol_d.dmactive;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dmcontrol_q <= '0;
            cmderr_q    <= CmdErrNone;
            command_q   <= '0;
            data_q      <= '0;
            cmd_valid_q <= 1'b0;
            ack_q       <= 1'b0;
        end else if (!active_d) begin
            dmcontrol_q <= '{dmactive: dmcontrol_d.dmactive, default: '0};
            cmderr_q    <= CmdErrNone;
            command_q   <= '0;
            data_q      <= '0;
            cmd_valid_q <= 1'b0;
            ack_q       <= 1'b0;
        end else begin
            dmcontrol_q <= dmcontrol_d;
            cmderr_q    <= cmderr_d;
            command_q   <= command_d;
            data_q      <= data_d;
            cmd_valid_q <= cmd_valid_d;
            ack_q       <= ack_d;
        end
    end

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    assign resp_push_o   = req_accept_i;
    assign dmactive_o    = dmcontrol_q.dmactive;
    assign cmd_valid_o   = cmd_valid_q;
    assign cmd_o         = command_q;
    assign data_o        = data_q;

    assign hart_if.hartsel       = dmcontrol_q.hartsello;
    assign hart_if.haltreq       = dmcontrol_q.haltreq;
    assign hart_if.resumereq     = dmcontrol_q.resumereq;
    assign hart_if.ndmreset      = dmcontrol_q.ndmreset;
    // acts on the hart selected by the same write
    assign hart_if.ack_havereset = ack_q;

endmodule

`default_nettype wire

// File: design/dm_hart_ctrl.sv
`include "dm_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module dm_hart_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    dm_hart_if.ctrl                 hart_if,
    input  logic [`DM_NR_HARTS-1:0] halted_i,
    input  logic [`DM_NR_HARTS-1:0] unavailable_i,
    input  logic [`DM_NR_HARTS-1:0] resumeack_i,
    output logic [`DM_NR_HARTS-1:0] haltreq_o,
    output logic [`DM_NR_HARTS-1:0] resumereq_o
);

    localparam int NrHarts = `DM_NR_HARTS;
    localparam int SelW    = (NrHarts > 1) ? $clog2(NrHarts) : 1;

    logic [SelW-1:0]    sel;
    logic               exists;
    logic               sel_halted;
    logic               sel_unavail;
    logic [NrHarts-1:0] havereset_q;

    // low bits index the hart, the full value decides existence
    assign sel    = hart_if.hartsel[SelW-1:0];
    assign exists = hart_if.hartsel < 10'(NrHarts);

    // --------------------------------------------------
    // havereset flags
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            havereset_q <= '1;
        end else if (hart_if.ndmreset) begin
            havereset_q <= '1;
        end else if (hart_if.ack_havereset && exists) begin
            havereset_q[sel] <= 1'b0;
        end
    end

    // --------------------------------------------------
    // status of the selected hart
    // --------------------------------------------------
    assign sel_unavail = exists & unavailable_i[sel];
    assign sel_halted  = exists & halted_i[sel];

    // halted and running are exclusive with unavailable
    assign hart_if.halted      = sel_halted & ~sel_unavail;
    assign hart_if.running     = exists & ~sel_halted & ~sel_unavail;
    assign hart_if.unavail     = sel_unavail;
    assign hart_if.nonexistent = ~exists;
    assign hart_if.resumeack   = exists & resumeack_i[sel];
    assign hart_if.havereset   = exists & havereset_q[sel];

    // one-hot requests, nothing for a missing hart
    always_comb begin
        haltreq_o   = '0;
        resumereq_o = '0;
        if (exists) begin
            haltreq_o[sel]   = hart_if.haltreq;
            resumereq_o[sel] = hart_if.resumereq;
        end
    end

endmodule

`default_nettype wire

// File: design/dm_hart_if.sv
`timescale 1ns/10ps
`default_nettype none

interface dm_hart_if;
    import dm_pkg::*;

    // requests from the register file
    hartsel_t hartsel;
    logic     haltreq;
    logic     resumereq;
    logic     ack_havereset;
    logic     ndmreset;

    // status of the selected hart
    logic     halted;
    logic     running;
    logic     unavail;
    logic     nonexistent;
    logic     resumeack;
    logic     havereset;

    modport csr (
        output hartsel, haltreq, resumereq, ack_havereset, ndmreset,
        input  halted, running, unavail, nonexistent, resumeack, havereset
    );

    modport ctrl (
        input  hartsel, haltreq, resumereq, ack_havereset, ndmreset,
        output halted, running, unavail, nonexistent, resumeack, havereset
    );

endinterface

`default_nettype wire

// File: design/dm_pkg.sv
`default_nettype none

package dm_pkg;

    // --------------------------------------------------
    // addresses and operations
    // --------------------------------------------------
    typedef enum logic [6:0] {
        Data0      = 7'h04,
        Data1      = 7'h05,
        DMControl  = 7'h10,
        DMStatus   = 7'h11,
        AbstractCS = 7'h16,
        Command    = 7'h17
    } dm_csr_e;

    typedef enum logic [1:0] {
        DTM_NOP   = 2'h0,
        DTM_READ  = 2'h1,
        DTM_WRITE = 2'h2
    } dtm_op_e;

    // codes other than none and busy come from the hart
    typedef enum logic [2:0] {
        CmdErrNone         = 3'h0,
        CmdErrBusy         = 3'h1,
        CmdErrNotSupported = 3'h2,
        CmdErrException    = 3'h3,
        CmdErrHalt         = 3'h4,
        CmdErrBus          = 3'h5,
        CmdErrOther        = 3'h7
    } cmderr_e;

    typedef logic [9:0] hartsel_t;

    // --------------------------------------------------
    // register layouts
    // --------------------------------------------------
    typedef struct packed {
        logic       haltreq;
        logic       resumereq;
        logic       zero3;
        logic       ackhavereset;
        logic [1:0] zero2;
        hartsel_t   hartsello;
        logic [13:0] zero1;
        logic       ndmreset;
        logic       dmactive;
    } dmcontrol_t;

    typedef struct packed {
        logic [11:0] zero2;
        logic        allhavereset;
        logic        anyhavereset;
        logic        allresumeack;
        logic        anyresumeack;
        logic        allnonexistent;
        logic        anynonexistent;
        logic        allunavail;
        logic        anyunavail;
        logic        allrunning;
        logic        anyrunning;
        logic        allhalted;
        logic        anyhalted;
        logic        authenticated;
        logic [2:0]  zero1;
        logic [3:0]  version;
    } dmstatus_t;

    typedef struct packed {
        logic [18:0] zero3;
        logic        busy;
        logic        zero2;
        cmderr_e     cmderr;
        logic [3:0]  zero1;
        logic [3:0]  datacount;
    } abstractcs_t;

    typedef struct packed {
        logic [7:0]  cmdtype;
        logic [23:0] control;
    } command_t;

    // one DMI write word, decoded by target register
    typedef union packed {
        dmcontrol_t  dmcontrol;
        abstractcs_t abstractcs;
        command_t    command;
    } dm_wdata_u;

endpackage

`default_nettype wire

// File: design/dm_settings.svh
`default_nettype none

`ifndef DM_SETTINGS_SVH
`define DM_SETTINGS_SVH

// harts behind this debug module
`define DM_NR_HARTS 4

// abstract data registers, data0 upward
`define DM_DATA_COUNT 2

// entries in the DMI response buffer
`define DM_RESP_DEPTH 2

// dmstatus.version, 2 means spec 0.13
`define DM_DBG_VERSION 2

`endif

`default_nettype wire
